//--- Makefile
TOP = tb_top_jtag_probe
SOURCES = $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): flist.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^Finished with no errors$$" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- flist.f
hw/jtag_probe_pkg.sv
hw/jtag_pin_sync.sv
hw/jtag_tap.sv
hw/trace_capture.sv
hw/hex_scanner.sv
hw/top_jtag_probe.sv
sim/tb_top_jtag_probe.sv

//--- hw/hex_scanner.sv
module hex_scanner (
    input  logic clk,
    input  logic reset,
    input  jtag_probe_pkg::capture_t hist_tms,
    input  jtag_probe_pkg::capture_t hist_tdi,
    input  jtag_probe_pkg::capture_t hist_tdo,
    output logic digit_valid,
    output jtag_probe_pkg::digit_t digit_index,
    output jtag_probe_pkg::nibble_t digit_nibble
);
    import jtag_probe_pkg::*;

    display_t                display;
    logic [C_scan_div_w-1:0] div_cnt;
    logic                    div_last;

    // row 0 shows recent tdi as binary digits, one bit per nibble
    // rows 1..3 are tms, tdi, tdo with time running left to right
    always_comb begin
        display = '0;
        for (int i = 0; i < C_row_digits; i++) begin
            display[4*i] = hist_tdi[i];
        end
        for (int i = 0; i < C_capture_bits; i++) begin
            display[1*C_row_digits*4 + C_capture_bits-1-i] = hist_tms[i];
            display[2*C_row_digits*4 + C_capture_bits-1-i] = hist_tdi[i];
            display[3*C_row_digits*4 + C_capture_bits-1-i] = hist_tdo[i];
        end
    end

    assign div_last = (div_cnt == C_scan_div_w'(C_scan_div - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            digit_valid <= 1'b0;
            digit_index <= '0;
        end else begin
            digit_valid <= div_last;
            if (div_last) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (digit_valid) begin
                digit_index <= digit_t'(digit_index + 1'b1); // wraps after 63
            end
        end
    end

    // follows the live word, so it is current during the pulse
    assign digit_nibble = display[4*digit_index +: 4];

    a_index_step: assert property (@(posedge clk) disable iff (reset)
        (digit_valid && $past(digit_valid, C_scan_div))
        |-> (digit_index == digit_t'($past(digit_index, C_scan_div) + 1'b1)));

endmodule

//--- hw/jtag_pin_sync.sv
module jtag_pin_sync (
    input  logic clk,
    input  logic reset,
    input  logic tck_pin,
    input  logic tms_pin,
    input  logic tdi_pin,
    output logic tck_rise,
    output logic tck_fall,
    output logic tms_s,
    output logic tdi_s
);

    // [0] and [1] form the synchronizer, [2] is the edge reference
    logic [2:0] tck_pipe;
    logic [2:0] tms_pipe;
    logic [2:0] tdi_pipe;

    always_ff @(posedge clk) begin
        if (reset) begin
            tck_pipe <= '0;
            tck_rise <= 1'b0;
            tck_fall <= 1'b0;
        end else begin
            tck_pipe <= {tck_pipe[1:0], tck_pin};
            tck_rise <= tck_pipe[1] & ~tck_pipe[2];
            tck_fall <= ~tck_pipe[1] & tck_pipe[2];
        end
    end

    // data pins get the same depth so they line up with the strobes
    always_ff @(posedge clk) begin
        tms_pipe <= {tms_pipe[1:0], tms_pin};
        tdi_pipe <= {tdi_pipe[1:0], tdi_pin};
    end

    assign tms_s = tms_pipe[2];
    assign tdi_s = tdi_pipe[2];

    a_single_edge: assert property (@(posedge clk) disable iff (reset)
        !(tck_rise && tck_fall));

endmodule

//--- hw/jtag_probe_pkg.sv
package jtag_probe_pkg;

    localparam int C_capture_bits = 64;   // history depth per signal
    localparam int C_row_digits   = 16;   // hex digits in one display row
    localparam int C_display_bits = 256;
    localparam int C_ir_len       = 4;
    localparam int C_user_len     = 8;
    localparam int C_idcode_len   = 32;

    localparam int C_scan_div     = 16;   // clk cycles per presented digit
    localparam int C_scan_div_w   = $clog2(C_scan_div);

    typedef logic [C_capture_bits-1:0] capture_t;
    typedef logic [C_display_bits-1:0] display_t;
    typedef logic [C_ir_len-1:0]       ir_t;
    typedef logic [C_user_len-1:0]     user_t;
    typedef logic [C_idcode_len-1:0]   idcode_t;
    typedef logic [5:0]                digit_t;
    typedef logic [3:0]                nibble_t;

    localparam idcode_t C_idcode    = 32'h1000_0001; // bit 0 must be 1
    localparam ir_t     C_ir_idcode = 4'b0001;
    localparam ir_t     C_ir_bypass = 4'b1111;
    localparam ir_t     C_ir_user   = 4'b1000;

    // encodings follow the usual 1149.1 numbering
    typedef enum logic [3:0] {
        exit2_dr         = 4'h0,
        exit1_dr         = 4'h1,
        shift_dr         = 4'h2,
        pause_dr         = 4'h3,
        select_ir_scan   = 4'h4,
        update_dr        = 4'h5,
        capture_dr       = 4'h6,
        select_dr_scan   = 4'h7,
        exit2_ir         = 4'h8,
        exit1_ir         = 4'h9,
        shift_ir         = 4'hA,
        pause_ir         = 4'hB,
        run_test_idle    = 4'hC,
        update_ir        = 4'hD,
        capture_ir       = 4'hE,
        test_logic_reset = 4'hF
    } tap_state_t;

endpackage

//--- hw/jtag_tap.sv
module jtag_tap (
    input  logic clk,
    input  logic reset,
    input  logic tck_rise,
    input  logic tck_fall,
    input  logic tms_s,
    input  logic tdi_s,
    output logic tdo,
    output jtag_probe_pkg::user_t user_value
);
    import jtag_probe_pkg::*;

    tap_state_t state;
    tap_state_t state_next;
    ir_t        ir;          // active instruction
    ir_t        ir_sr;       // instruction shift path
    idcode_t    idcode_sr;
    logic       bypass_sr;
    user_t      user_sr;
    logic       tdo_next;
    logic [2:0] tms_high_run; // rising strobes in a row with tms high, saturates at 5

    always_comb begin
        case (state)
            test_logic_reset: state_next = tms_s ? test_logic_reset : run_test_idle;
            run_test_idle:    state_next = tms_s ? select_dr_scan   : run_test_idle;
            select_dr_scan:   state_next = tms_s ? select_ir_scan   : capture_dr;
            capture_dr:       state_next = tms_s ? exit1_dr         : shift_dr;
            shift_dr:         state_next = tms_s ? exit1_dr         : shift_dr;
            exit1_dr:         state_next = tms_s ? update_dr        : pause_dr;
            pause_dr:         state_next = tms_s ? exit2_dr         : pause_dr;
            exit2_dr:         state_next = tms_s ? update_dr        : shift_dr;
            update_dr:        state_next = tms_s ? select_dr_scan   : run_test_idle;
            select_ir_scan:   state_next = tms_s ? test_logic_reset : capture_ir;
            capture_ir:       state_next = tms_s ? exit1_ir         : shift_ir;
            shift_ir:         state_next = tms_s ? exit1_ir         : shift_ir;
            exit1_ir:         state_next = tms_s ? update_ir        : pause_ir;
            pause_ir:         state_next = tms_s ? exit2_ir         : pause_ir;
            exit2_ir:         state_next = tms_s ? update_ir        : shift_ir;
            update_ir:        state_next = tms_s ? select_dr_scan   : run_test_idle;
            default:          state_next = test_logic_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= test_logic_reset;
        end else if (tck_rise) begin
            state <= state_next;
        end
    end

    // instruction shift path, LSB leaves first
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            if (state == capture_ir) begin
                ir_sr <= ir_t'(1); // fixed 01 capture pattern
            end else if (state == shift_ir) begin
                ir_sr <= {tdi_s, ir_sr[C_ir_len-1:1]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ir <= C_ir_idcode;
        end else if (state == test_logic_reset) begin
            ir <= C_ir_idcode;
        end else if (tck_fall && state == update_ir) begin
            ir <= ir_sr;
        end
    end

    // data shift paths, all loaded on capture, only the selected one shifts
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            if (state == capture_dr) begin
                idcode_sr <= C_idcode;
                bypass_sr <= 1'b0;
                user_sr   <= user_value;
            end else if (state == shift_dr) begin
                case (ir)
                    C_ir_idcode: idcode_sr <= {tdi_s, idcode_sr[C_idcode_len-1:1]};
                    C_ir_user:   user_sr   <= {tdi_s, user_sr[C_user_len-1:1]};
                    default:     bypass_sr <= tdi_s; // C_ir_bypass and undefined codes
                endcase
            end
        end
    end

    // survives Test-Logic-Reset, only the system reset clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            user_value <= '0;
        end else if (tck_fall && state == update_dr && ir == C_ir_user) begin
            user_value <= user_sr;
        end
    end

    always_comb begin
        tdo_next = 1'b0;
        if (state == shift_ir) begin
            tdo_next = ir_sr[0];
        end else if (state == shift_dr) begin
            case (ir)
                C_ir_idcode: tdo_next = idcode_sr[0];
                C_ir_user:   tdo_next = user_sr[0];
                default:     tdo_next = bypass_sr;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tdo <= 1'b0;
        end else if (tck_fall) begin
            tdo <= tdo_next; // launched on the falling edge
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tms_high_run <= '0;
        end else if (tck_rise) begin
            if (!tms_s) begin
                tms_high_run <= '0;
            end else if (tms_high_run != 3'd5) begin
                tms_high_run <= tms_high_run + 3'd1;
            end
        end
    end

    a_tms_reset: assert property (@(posedge clk) disable iff (reset)
        (tms_high_run == 3'd5) |-> (state == test_logic_reset));

    // last shifted bit stays on tdo through exit1 until the next fall
    a_tdo_idle: assert property (@(posedge clk) disable iff (reset)
        !(state inside {shift_dr, exit1_dr, shift_ir, exit1_ir}) |-> !tdo);

endmodule

//--- hw/top_jtag_probe.sv
module top_jtag_probe (
    input  logic        clk_25mhz,
    input  logic        reset,
    input  logic [6:0]  btn,
    input  logic        ftdi_ndtr, // TCK
    input  logic        ftdi_nrts, // TMS
    input  logic        ftdi_txd,  // TDI
    output logic        ftdi_rxd,  // TDO
    output logic [7:0]  led,
    output logic        digit_valid,
    output jtag_probe_pkg::digit_t  digit_index,
    output jtag_probe_pkg::nibble_t digit_nibble
);
    import jtag_probe_pkg::*;

    logic     clk;
    logic     tck_rise;
    logic     tck_fall;
    logic     tms_s;
    logic     tdi_s;
    logic     tdo;
    user_t    user_value;
    capture_t hist_tms;
    capture_t hist_tdi;
    capture_t hist_tdo;

    assign clk = clk_25mhz; // pins are sampled, tck is not a clock here

    jtag_pin_sync jtag_pin_sync_inst (
        .clk      (clk),
        .reset    (reset),
        .tck_pin  (ftdi_ndtr),
        .tms_pin  (ftdi_nrts),
        .tdi_pin  (ftdi_txd),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tms_s    (tms_s),
        .tdi_s    (tdi_s)
    );

    jtag_tap jtag_tap_inst (
        .clk        (clk),
        .reset      (reset),
        .tck_rise   (tck_rise),
        .tck_fall   (tck_fall),
        .tms_s      (tms_s),
        .tdi_s      (tdi_s),
        .tdo        (tdo),
        .user_value (user_value)
    );

    assign ftdi_rxd = tdo;
    assign led      = user_value;

    trace_capture trace_capture_inst (
        .clk      (clk),
        .reset    (reset),
        .tck_rise (tck_rise),
        .freeze   (btn[1]), // hold to freeze the trace
        .tms_s    (tms_s),
        .tdi_s    (tdi_s),
        .tdo      (tdo),
        .hist_tms (hist_tms),
        .hist_tdi (hist_tdi),
        .hist_tdo (hist_tdo)
    );

    hex_scanner hex_scanner_inst (
        .clk          (clk),
        .reset        (reset),
        .hist_tms     (hist_tms),
        .hist_tdi     (hist_tdi),
        .hist_tdo     (hist_tdo),
        .digit_valid  (digit_valid),
        .digit_index  (digit_index),
        .digit_nibble (digit_nibble)
    );

endmodule

//--- hw/trace_capture.sv
module trace_capture (
    input  logic clk,
    input  logic reset,
    input  logic tck_rise,
    input  logic freeze,
    input  logic tms_s,
    input  logic tdi_s,
    input  logic tdo,
    output jtag_probe_pkg::capture_t hist_tms,
    output jtag_probe_pkg::capture_t hist_tdi,
    output jtag_probe_pkg::capture_t hist_tdo
);
    import jtag_probe_pkg::*;

    logic shift_en;

    // a held button keeps the picture still while the bus runs on
    assign shift_en = tck_rise && !freeze;

    // bit 0 is the newest sample, older ones walk toward the MSB
    always_ff @(posedge clk) begin
        if (reset) begin
            hist_tms <= '0;
            hist_tdi <= '0;
            hist_tdo <= '0;
        end else if (shift_en) begin
            hist_tms <= {hist_tms[C_capture_bits-2:0], tms_s};
            hist_tdi <= {hist_tdi[C_capture_bits-2:0], tdi_s};
            hist_tdo <= {hist_tdo[C_capture_bits-2:0], tdo}; // tdo as driven at this edge
        end
    end

endmodule

//--- sim/tb_top_jtag_probe.sv
module tb_top_jtag_probe;
    import jtag_probe_pkg::*;

    localparam int          C_num_tests   = 7;
    localparam int          C_half_period = 8;  // clk cycles per TCK half-period
    localparam int          C_reset_clk   = 16;
    localparam int          C_watchdog_clk = C_num_tests * 200 * 2 * C_half_period + C_reset_clk;
    localparam logic [31:0] C_seed        = 32'hbf5c_c2b4;

    logic    clk;
    logic    reset;
    logic [6:0] btn;
    logic    tck;
    logic    tms;
    logic    tdi;
    logic    tdo;
    logic [7:0] led;
    logic    digit_valid;
    digit_t  digit_index;
    nibble_t digit_nibble;

    // model of what the probe should have recorded, bit 0 newest
    capture_t model_tms;
    capture_t model_tdi;
    capture_t model_tdo;
    int       error_count;
    int       failed_tests;

    // test table
    string       t_name [C_num_tests];
    logic        t_tms_reset [C_num_tests]; // five TMS-high clocks first
    logic        t_load_ir [C_num_tests];
    ir_t         t_ir [C_num_tests];
    int          t_len [C_num_tests];
    logic [63:0] t_din [C_num_tests];
    logic [63:0] t_dout [C_num_tests];
    user_t       t_led [C_num_tests];
    logic        t_freeze [C_num_tests];

    top_jtag_probe UUT (
        .clk_25mhz    (clk),
        .reset        (reset),
        .btn          (btn),
        .ftdi_ndtr    (tck),
        .ftdi_nrts    (tms),
        .ftdi_txd     (tdi),
        .ftdi_rxd     (tdo),
        .led          (led),
        .digit_valid  (digit_valid),
        .digit_index  (digit_index),
        .digit_nibble (digit_nibble)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // returns 1 unit after a rising clk edge, where all inputs change
    task automatic wait_clk(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", what, expected, actual);
            error_count++;
        end
    endtask

    // one full TCK period, TDO taken just before the rising edge
    task automatic tck_cycle(input logic tms_bit, input logic tdi_bit, output logic tdo_bit);
        tms = tms_bit;
        tdi = tdi_bit;
        wait_clk(C_half_period);
        tdo_bit = tdo;
        tck = 1'b1;
        if (!btn[1]) begin
            model_tms = {model_tms[C_capture_bits-2:0], tms_bit};
            model_tdi = {model_tdi[C_capture_bits-2:0], tdi_bit};
            model_tdo = {model_tdo[C_capture_bits-2:0], tdo_bit};
        end
        wait_clk(C_half_period);
        tck = 1'b0;
    endtask

    task automatic tap_reset();
        logic b;
        repeat (5) tck_cycle(1'b1, 1'b0, b);
    endtask

    // starts in Run-Test-Idle or Test-Logic-Reset, ends in Run-Test-Idle
    task automatic scan_ir(input ir_t code, output ir_t captured);
        logic b;
        tck_cycle(1'b0, 1'b0, b); // run-test-idle
        tck_cycle(1'b1, 1'b0, b); // select-dr
        tck_cycle(1'b1, 1'b0, b); // select-ir
        tck_cycle(1'b0, 1'b0, b); // capture-ir
        tck_cycle(1'b0, 1'b0, b); // shift-ir
        for (int k = 0; k < C_ir_len; k++) begin
            tck_cycle(k == C_ir_len - 1, code[k], b);
            captured[k] = b;
        end
        tck_cycle(1'b1, 1'b0, b); // update-ir
        tck_cycle(1'b0, 1'b0, b);
    endtask

    task automatic scan_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic b;
        dout = '0;
        tck_cycle(1'b0, 1'b0, b);
        tck_cycle(1'b1, 1'b0, b); // select-dr
        tck_cycle(1'b0, 1'b0, b); // capture-dr
        tck_cycle(1'b0, 1'b0, b); // shift-dr
        for (int k = 0; k < len; k++) begin
            tck_cycle(k == len - 1, din[k], b);
            dout[k] = b;
        end
        tck_cycle(1'b1, 1'b0, b); // update-dr
        tck_cycle(1'b0, 1'b0, b);
    endtask

    // display layout: row 0 tdi as one bit per digit, rows 1..3 tms, tdi, tdo reversed
    function automatic nibble_t expected_nibble(input digit_t idx);
        nibble_t n;
        int      p;
        int      row;
        int      pos;
        n = '0;
        for (int b = 0; b < 4; b++) begin
            p   = 4 * idx + b;
            row = p / 64;
            pos = 63 - (p - 64 * row);
            case (row)
                0:       n[b] = (b == 0 && idx < C_row_digits) ? model_tdi[idx] : 1'b0;
                1:       n[b] = model_tms[pos];
                2:       n[b] = model_tdi[pos];
                default: n[b] = model_tdo[pos];
            endcase
        end
        return n;
    endfunction

    task automatic collect_digits(input string name);
        int          pulses;
        logic [63:0] seen;
        pulses = 0;
        seen   = '0;
        while (pulses < 64) begin
            wait_clk(1);
            if (digit_valid) begin
                compare_value($sformatf("%s digit %0d", name, digit_index),
                              {60'h0, expected_nibble(digit_index)}, {60'h0, digit_nibble});
                seen[digit_index] = 1'b1;
                pulses++;
            end
        end
        compare_value($sformatf("%s digit sweep", name), '1, seen);
    endtask

    task automatic build_table();
        logic [15:0] r16;
        logic [31:0] r32;
        user_t       a;
        user_t       b;
        r32 = $urandom;
        a   = user_t'($urandom);
        b   = user_t'($urandom);
        for (int i = 0; i < C_num_tests; i++) begin
            t_tms_reset[i] = 1'b0;
            t_load_ir[i]   = 1'b1;
            t_freeze[i]    = 1'b0;
        end
        // idcode is selected straight out of reset
        t_name[0] = "idcode_after_reset"; t_load_ir[0] = 1'b0; t_ir[0] = '0;
        t_len[0] = 32; t_din[0] = {32'h0, r32}; t_dout[0] = {32'h0, C_idcode}; t_led[0] = '0;
        for (int i = 1; i <= 2; i++) begin
            r16 = 16'($urandom);
            t_len[i]  = 16;
            t_din[i]  = {48'h0, r16};
            t_dout[i] = {48'h0, r16[14:0], 1'b0}; // one bit late behind a leading 0
            t_led[i]  = '0;
        end
        t_name[1] = "bypass";           t_ir[1] = C_ir_bypass;
        t_name[2] = "bypass_undefined"; t_ir[2] = 4'b0101;
        t_name[3] = "user_write_a"; t_ir[3] = C_ir_user; t_len[3] = C_user_len;
        t_din[3] = {56'h0, a}; t_dout[3] = '0; t_led[3] = a;
        t_name[4] = "user_write_b"; t_ir[4] = C_ir_user; t_len[4] = C_user_len;
        t_din[4] = {56'h0, b}; t_dout[4] = {56'h0, a}; t_led[4] = b;
        r16 = 16'($urandom);
        t_name[5] = "frozen_trace"; t_ir[5] = C_ir_bypass; t_len[5] = 16; t_freeze[5] = 1'b1;
        t_din[5] = {48'h0, r16}; t_dout[5] = {48'h0, r16[14:0], 1'b0}; t_led[5] = b;
        r32 = $urandom;
        t_name[6] = "tms_reset"; t_tms_reset[6] = 1'b1; t_load_ir[6] = 1'b0; t_ir[6] = '0;
        t_len[6] = 32; t_din[6] = {32'h0, r32}; t_dout[6] = {32'h0, C_idcode}; t_led[6] = b;
    endtask

    initial begin
        int          errors_before;
        ir_t         ir_captured;
        logic [63:0] dout;
        void'($urandom(C_seed));
        reset        = 1'b1;
        btn          = '0;
        tck          = 1'b0;
        tms          = 1'b1;
        tdi          = 1'b0;
        model_tms    = '0;
        model_tdi    = '0;
        model_tdo    = '0;
        error_count  = 0;
        failed_tests = 0;
        build_table();
        wait_clk(C_reset_clk);
        reset = 1'b0;

        for (int i = 0; i < C_num_tests; i++) begin
            errors_before = error_count;
            btn[1] = t_freeze[i];
            if (t_tms_reset[i]) begin
                tap_reset();
            end
            if (t_load_ir[i]) begin
                scan_ir(t_ir[i], ir_captured);
                // Capture-IR pattern
                compare_value({t_name[i], " ir_capture"}, 64'h1, {60'h0, ir_captured});
            end
            scan_dr(t_len[i], t_din[i], dout);
            btn[1] = 1'b0;
            compare_value({t_name[i], " dr_out"}, t_dout[i], dout);
            compare_value({t_name[i], " led"}, {56'h0, t_led[i]}, {56'h0, led});
            collect_digits(t_name[i]);
            if (error_count == errors_before) begin
                $display("test %0d %s: ok", i, t_name[i]);
            end else begin
                $display("test %0d %s: %0d mismatches", i, t_name[i],
                         error_count - errors_before);
                failed_tests++;
            end
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 C_num_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait_clk(C_watchdog_clk);
        $display("timeout: the tests did not finish within %0d clock cycles", C_watchdog_clk);
        $display("Finished with errors");
        $finish;
    end

endmodule
